// ==== mips_pkg.sv ====
package mips_pkg;

    // data word, also used for byte addresses
    typedef logic [31:0] word_t;

    // gpr number, rs / rt / rd fields
    typedef logic [4:0] creg_addr_t;

    // byte write enables on the wb trace
    typedef logic [3:0] rwen_t;

    // alu function select
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } alu_op_t;

    // multicycle sequencer, one instruction in flight
    typedef enum logic [1:0] {
        S_FETCH,
        S_EXECUTE,
        S_MEMORY,
        S_WRITEBACK
    } cpu_state_t;

    // primary opcode, instr[31:26]
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct under OP_SPECIAL, instr[5:0]
    localparam logic [5:0] FN_ADDU    = 6'h21;
    localparam logic [5:0] FN_SUBU    = 6'h23;
    localparam logic [5:0] FN_AND     = 6'h24;
    localparam logic [5:0] FN_OR      = 6'h25;
    localparam logic [5:0] FN_SLT     = 6'h2a;

endpackage

// ==== handshake.sv ====
`timescale 1ns/100ps

module handshake (
    input  logic clk,
    input  logic rst_n,
    input  logic cpu_req,
    input  logic addr_ok,
    input  logic data_ok,
    output logic req,
    output logic cpu_data_ok
);

    // idle: address phase open, wait: address taken, data pending
    typedef enum logic {
        HS_IDLE,
        HS_WAIT
    } hs_state_t;

    hs_state_t state;
    hs_state_t state_next;

    // request passes straight through from idle only
    // held low in wait so a level cpu_req cannot start a second transfer
    assign req = (state == HS_IDLE) && cpu_req;

    // data_ok normally lands in wait
    // a fast slave may also answer in the addr_ok cycle
    assign cpu_data_ok = data_ok && ((state == HS_WAIT) || (req && addr_ok));

    always_comb begin
        state_next = state;
        case (state)
            HS_IDLE: begin
                // address accepted, data still to come
                if (req && addr_ok && !data_ok) begin
                    state_next = HS_WAIT;
                end
            end
            HS_WAIT: begin
                // transfer done, back to accepting requests
                if (data_ok) begin
                    state_next = HS_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= HS_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

// ==== regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::creg_addr_t ra1,
    input  mips_pkg::creg_addr_t ra2,
    input  logic                 we,
    input  mips_pkg::creg_addr_t wa,
    input  mips_pkg::word_t      wd,
    output mips_pkg::word_t      rd1,
    output mips_pkg::word_t      rd2
);

    // $1..$31 only, $0 has no storage
    mips_pkg::word_t regs [1:31];

    // async read ports
    // $0 always reads zero
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != 5'd0)) begin
            // writes to $0 dropped
            regs[wa] <= wd;
        end
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu (
    input  mips_pkg::alu_op_t op,
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    output mips_pkg::word_t   y,
    output logic              zero
);

    logic lt;

    // signed compare for slt
    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            // addu / addiu / lw / sw address, no overflow trap
            mips_pkg::ALU_ADD: y = a + b;
            mips_pkg::ALU_SUB: y = a - b;
            mips_pkg::ALU_AND: y = a & b;
            mips_pkg::ALU_OR:  y = a | b;
            mips_pkg::ALU_SLT: y = {31'b0, lt};
            // immediate into upper half, b carries the raw imm
            mips_pkg::ALU_LUI: y = {b[15:0], 16'h0000};
            default:           y = '0;
        endcase
    end

    // equality flag for beq / bne
    assign zero = (a == b);

endmodule

// ==== decoder.sv ====
`timescale 1ns/100ps

module decoder (
    input  mips_pkg::word_t   instr,
    output mips_pkg::alu_op_t alu_op,
    output logic              use_imm,
    output logic              sign_ext,
    output logic              rf_we,
    output logic              dst_rt,
    output logic              mem_read,
    output logic              mem_write,
    output logic              branch_eq,
    output logic              branch_ne,
    output logic              jump
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // unknown encodings fall through as a nop
        alu_op    = mips_pkg::ALU_ADD;
        use_imm   = 1'b0;
        sign_ext  = 1'b0;
        rf_we     = 1'b0;
        dst_rt    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch_eq = 1'b0;
        branch_ne = 1'b0;
        jump      = 1'b0;
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                // r-type, dest in rd
                rf_we = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
                    // sll $0 style nops and the rest
                    default:           rf_we  = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                use_imm  = 1'b1;
                sign_ext = 1'b1;
                rf_we    = 1'b1;
                dst_rt   = 1'b1;
            end
            mips_pkg::OP_LUI: begin
                // zero-extended imm, alu shifts it up
                alu_op  = mips_pkg::ALU_LUI;
                use_imm = 1'b1;
                rf_we   = 1'b1;
                dst_rt  = 1'b1;
            end
            mips_pkg::OP_LW: begin
                use_imm  = 1'b1;
                sign_ext = 1'b1;
                rf_we    = 1'b1;
                dst_rt   = 1'b1;
                mem_read = 1'b1;
            end
            mips_pkg::OP_SW: begin
                use_imm   = 1'b1;
                sign_ext  = 1'b1;
                mem_write = 1'b1;
            end
            // branches compare rs against rt
            mips_pkg::OP_BEQ: begin
                alu_op    = mips_pkg::ALU_SUB;
                branch_eq = 1'b1;
            end
            mips_pkg::OP_BNE: begin
                alu_op    = mips_pkg::ALU_SUB;
                branch_ne = 1'b1;
            end
            mips_pkg::OP_J: jump = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== datapath.sv ====
`timescale 1ns/100ps

module datapath (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::word_t      instr,
    input  mips_pkg::word_t      rd,
    input  logic                 i_data_ok,
    input  logic                 d_data_ok,
    output mips_pkg::word_t      pc,
    output logic                 i_req,
    output logic                 d_req,
    output logic                 d_wr,
    output mips_pkg::word_t      d_addr,
    output mips_pkg::word_t      d_wdata,
    output mips_pkg::word_t      wb_pc,
    output mips_pkg::rwen_t      wb_wen,
    output mips_pkg::creg_addr_t wb_wnum,
    output mips_pkg::word_t      wb_wdata
);

    // boot rom entry
    localparam mips_pkg::word_t RESET_PC = 32'hbfc0_0000;

    mips_pkg::cpu_state_t state;
    logic                 started;
    mips_pkg::word_t      pc_q;
    mips_pkg::word_t      npc_q;
    mips_pkg::word_t      ir;
    mips_pkg::word_t      alu_q;
    mips_pkg::word_t      load_q;

    mips_pkg::alu_op_t    alu_op;
    logic                 use_imm;
    logic                 sign_ext;
    logic                 rf_we;
    logic                 dst_rt;
    logic                 mem_read;
    logic                 mem_write;
    logic                 branch_eq;
    logic                 branch_ne;
    logic                 jump;

    mips_pkg::word_t      rs_val;
    mips_pkg::word_t      rt_val;
    mips_pkg::word_t      imm_ext;
    mips_pkg::word_t      alu_b;
    mips_pkg::word_t      alu_y;
    logic                 alu_zero;
    mips_pkg::word_t      pc_plus4;
    mips_pkg::word_t      br_target;
    mips_pkg::word_t      j_target;
    mips_pkg::word_t      next_pc;
    logic                 taken;
    logic                 in_wb;

    // controls come from the latched instruction
    decoder decoder (
        .instr(ir), .alu_op, .use_imm, .sign_ext, .rf_we, .dst_rt,
        .mem_read, .mem_write, .branch_eq, .branch_ne, .jump
    );

    // operands stay valid from execute to writeback, ir and regs are frozen
    regfile regfile (
        .clk, .rst_n,
        .ra1(ir[25:21]), .ra2(ir[20:16]),
        .we(in_wb && rf_we), .wa(wb_wnum), .wd(wb_wdata),
        .rd1(rs_val), .rd2(rt_val)
    );

    assign imm_ext = sign_ext ? {{16{ir[15]}}, ir[15:0]} : {16'h0000, ir[15:0]};
    assign alu_b   = use_imm ? imm_ext : rt_val;

    alu alu (.op(alu_op), .a(rs_val), .b(alu_b), .y(alu_y), .zero(alu_zero));

    // no delay slot, targets relative to pc+4
    assign pc_plus4  = pc_q + 32'd4;
    assign br_target = pc_plus4 + {{14{ir[15]}}, ir[15:0], 2'b00};
    assign j_target  = {pc_plus4[31:28], ir[25:0], 2'b00};
    assign taken     = (branch_eq && alu_zero) || (branch_ne && !alu_zero);

    always_comb begin
        if (jump) begin
            next_pc = j_target;
        end else if (taken) begin
            next_pc = br_target;
        end else begin
            next_pc = pc_plus4;
        end
    end

    // sequencer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= mips_pkg::S_FETCH;
            started <= 1'b0;
            pc_q    <= RESET_PC;
        end else begin
            // first fetch request one cycle after reset release
            started <= 1'b1;
            case (state)
                mips_pkg::S_FETCH: begin
                    if (i_data_ok) begin
                        state <= mips_pkg::S_EXECUTE;
                    end
                end
                mips_pkg::S_EXECUTE: begin
                    // only lw / sw touch the data bus
                    if (mem_read || mem_write) begin
                        state <= mips_pkg::S_MEMORY;
                    end else begin
                        state <= mips_pkg::S_WRITEBACK;
                    end
                end
                mips_pkg::S_MEMORY: begin
                    if (d_data_ok) begin
                        state <= mips_pkg::S_WRITEBACK;
                    end
                end
                mips_pkg::S_WRITEBACK: begin
                    state <= mips_pkg::S_FETCH;
                    pc_q  <= npc_q;
                end
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if ((state == mips_pkg::S_FETCH) && i_data_ok) begin
            ir <= instr;
        end
        if (state == mips_pkg::S_EXECUTE) begin
            alu_q <= alu_y;
            npc_q <= next_pc;
        end
        // rdata valid only in the data_ok cycle
        if ((state == mips_pkg::S_MEMORY) && d_data_ok) begin
            load_q <= rd;
        end
    end

    // bus requests, held as levels while waiting
    assign pc      = pc_q;
    assign i_req   = started && (state == mips_pkg::S_FETCH);
    assign d_req   = (state == mips_pkg::S_MEMORY);
    assign d_wr    = (state == mips_pkg::S_MEMORY) && mem_write;
    assign d_addr  = alu_q;
    assign d_wdata = rt_val;

    // wb trace
    assign in_wb    = (state == mips_pkg::S_WRITEBACK);
    assign wb_pc    = pc_q;
    assign wb_wnum  = dst_rt ? ir[20:16] : ir[15:11];
    assign wb_wdata = mem_read ? load_q : alu_q;
    // $0 writes are invisible on the trace
    assign wb_wen   = {4{in_wb && rf_we && (wb_wnum != 5'd0)}};

endmodule

// ==== mycpu.sv ====
`timescale 1ns/100ps

module mycpu (
    input  logic                 clk,
    input  logic                 rst_n,

    output logic                 inst_req,
    output logic                 data_req,
    output logic                 inst_wr,
    output logic                 data_wr,
    output logic [1:0]           inst_size,
    output logic [1:0]           data_size,
    output mips_pkg::word_t      inst_addr,
    output mips_pkg::word_t      data_addr,
    output mips_pkg::word_t      inst_wdata,
    output mips_pkg::word_t      data_wdata,
    input  mips_pkg::word_t      inst_rdata,
    input  mips_pkg::word_t      data_rdata,
    input  logic                 inst_addr_ok,
    input  logic                 data_addr_ok,
    input  logic                 inst_data_ok,
    input  logic                 data_data_ok,

    // write-back trace
    output mips_pkg::word_t      debug_wb_pc,
    output mips_pkg::rwen_t      debug_wb_rf_wen,
    output mips_pkg::creg_addr_t debug_wb_rf_wnum,
    output mips_pkg::word_t      debug_wb_rf_wdata
);

    logic i_req;
    logic d_req;
    logic i_data_ok;
    logic d_data_ok;

    datapath datapath (
        .clk, .rst_n,
        .instr(inst_rdata), .rd(data_rdata),
        .i_data_ok, .d_data_ok,
        .pc(inst_addr), .i_req, .d_req,
        .d_wr(data_wr), .d_addr(data_addr), .d_wdata(data_wdata),
        .wb_pc(debug_wb_pc), .wb_wen(debug_wb_rf_wen),
        .wb_wnum(debug_wb_rf_wnum), .wb_wdata(debug_wb_rf_wdata)
    );

    // instruction side, read-only word fetches
    assign inst_wr    = 1'b0;
    assign inst_size  = 2'b10;
    assign inst_wdata = '0;

    // word-only loads and stores
    assign data_size  = 2'b10;

    handshake i_handshake (
        .clk, .rst_n, .cpu_req(i_req),
        .addr_ok(inst_addr_ok), .data_ok(inst_data_ok),
        .req(inst_req), .cpu_data_ok(i_data_ok)
    );

    handshake d_handshake (
        .clk, .rst_n, .cpu_req(d_req),
        .addr_ok(data_addr_ok), .data_ok(data_data_ok),
        .req(data_req), .cpu_data_ok(d_data_ok)
    );

endmodule

// ==== tb_mycpu.sv ====
`timescale 1ns/100ps

module tb_mycpu;

    localparam mips_pkg::word_t BASE       = 32'hbfc0_0000;
    // j-to-self at word 28 of the program
    localparam mips_pkg::word_t LOOP_PC    = 32'hbfc0_0070;
    localparam mips_pkg::word_t IDLE_RDATA = 32'h0bad_f00d;
    // dynamic instruction bound and worst cycles each with 3+3 waits per bus phase
    localparam int MAX_STEPS  = 40;
    localparam int WORST_CPI  = 18;
    localparam int TIMEOUT_NS = 2 * MAX_STEPS * WORST_CPI * 8 + 200;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 inst_req;
    logic                 data_req;
    logic                 inst_wr;
    logic                 data_wr;
    logic [1:0]           inst_size;
    logic [1:0]           data_size;
    mips_pkg::word_t      inst_addr;
    mips_pkg::word_t      data_addr;
    mips_pkg::word_t      inst_wdata;
    mips_pkg::word_t      data_wdata;
    mips_pkg::word_t      inst_rdata;
    mips_pkg::word_t      data_rdata;
    logic                 inst_addr_ok;
    logic                 data_addr_ok;
    logic                 inst_data_ok;
    logic                 data_data_ok;
    mips_pkg::word_t      debug_wb_pc;
    mips_pkg::rwen_t      debug_wb_rf_wen;
    mips_pkg::creg_addr_t debug_wb_rf_wnum;
    mips_pkg::word_t      debug_wb_rf_wdata;

    // bus memory and the reference copy indexed by addr[9:2]
    mips_pkg::word_t mem     [0:255];
    mips_pkg::word_t ref_mem [0:255];
    mips_pkg::word_t rf      [0:31];
    mips_pkg::word_t ref_pc;
    logic [31:0]     lfsr = 32'h21c6_fe5b;
    int              n_checks;
    int              n_errors;
    int              post_rst_cnt;
    logic            done;

    // slave state per channel
    logic            i_busy;
    logic            i_held;
    logic [1:0]      i_await;
    logic [1:0]      i_dwait;
    mips_pkg::word_t i_addr_q;
    mips_pkg::word_t i_hold_addr;
    logic [2:0]      i_hold_ctrl;
    mips_pkg::word_t i_hold_wdata;
    logic            d_busy;
    logic            d_held;
    logic [1:0]      d_await;
    logic [1:0]      d_dwait;
    logic            d_wr_q;
    mips_pkg::word_t d_addr_q;
    logic            d_hold_wr;
    logic [1:0]      d_hold_size;
    mips_pkg::word_t d_hold_addr;
    mips_pkg::word_t d_hold_wdata;

    // predicted trace writes and data accesses in program order
    mips_pkg::word_t      wb_pc_q[$];
    mips_pkg::creg_addr_t wb_num_q[$];
    mips_pkg::word_t      wb_data_q[$];
    logic                 acc_wr_q[$];
    mips_pkg::word_t      acc_addr_q[$];
    mips_pkg::word_t      acc_data_q[$];

    mycpu DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [1:0] draw_delay();
        logic [1:0] d;
        // one galois step per bit
        for (int i = 0; i < 2; i++) begin
            d[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return d;
    endfunction

    task automatic check_val(input string name, input mips_pkg::word_t got,
                             input mips_pkg::word_t exp);
        n_checks++;
        assert (got == exp) else begin
            n_errors++;
            $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            n_errors++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    function automatic mips_pkg::word_t rtype_word(input logic [5:0] fn, input int rs,
                                                   input int rt, input int rd);
        return {mips_pkg::OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic mips_pkg::word_t itype_word(input logic [5:0] op, input int rs,
                                                   input int rt, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic mips_pkg::word_t jump_word(input int idx);
        mips_pkg::word_t t;
        t = BASE + (idx << 2);
        return {mips_pkg::OP_J, t[27:2]};
    endfunction

    task automatic store_word(input int idx, input mips_pkg::word_t w);
        mem[idx]     = w;
        ref_mem[idx] = w;
    endtask

    task automatic load_program();
        // every word starts as a pattern of its full address
        for (int i = 0; i < 256; i++) begin
            store_word(i, (BASE + (i << 2)) ^ 32'ha5c3_3c5a);
        end
        store_word(0,  itype_word(mips_pkg::OP_LUI, 0, 1, 'hbfc0));
        // $1 = data area at word 128
        store_word(1,  itype_word(mips_pkg::OP_ADDIU, 1, 1, 'h200));
        store_word(2,  itype_word(mips_pkg::OP_LW, 1, 2, 0));
        store_word(3,  itype_word(mips_pkg::OP_LW, 1, 3, 4));
        store_word(4,  rtype_word(mips_pkg::FN_ADDU, 2, 3, 4));
        store_word(5,  rtype_word(mips_pkg::FN_SUBU, 2, 3, 5));
        store_word(6,  rtype_word(mips_pkg::FN_AND, 2, 3, 6));
        store_word(7,  rtype_word(mips_pkg::FN_OR, 2, 3, 7));
        store_word(8,  rtype_word(mips_pkg::FN_SLT, 2, 3, 8));
        store_word(9,  itype_word(mips_pkg::OP_ADDIU, 0, 9, -5));
        // negative against zero
        store_word(10, rtype_word(mips_pkg::FN_SLT, 9, 0, 10));
        // write to $0 that must stay off the trace
        store_word(11, rtype_word(mips_pkg::FN_ADDU, 2, 3, 0));
        store_word(12, itype_word(mips_pkg::OP_SW, 1, 4, 8));
        store_word(13, itype_word(mips_pkg::OP_SW, 1, 10, 12));
        store_word(14, itype_word(mips_pkg::OP_BEQ, 2, 3, 5));
        store_word(15, itype_word(mips_pkg::OP_BNE, 2, 3, 2));
        store_word(16, itype_word(mips_pkg::OP_ADDIU, 0, 11, 1));
        store_word(17, itype_word(mips_pkg::OP_ADDIU, 0, 11, 2));
        store_word(18, itype_word(mips_pkg::OP_BEQ, 9, 9, 1));
        store_word(19, itype_word(mips_pkg::OP_ADDIU, 0, 12, 3));
        store_word(20, itype_word(mips_pkg::OP_BNE, 0, 0, 3));
        store_word(21, jump_word(23));
        store_word(22, itype_word(mips_pkg::OP_ADDIU, 0, 13, 4));
        // three-pass countdown with a backward bne
        store_word(23, itype_word(mips_pkg::OP_ADDIU, 0, 15, 3));
        store_word(24, itype_word(mips_pkg::OP_ADDIU, 15, 15, -1));
        store_word(25, itype_word(mips_pkg::OP_BNE, 15, 0, -2));
        store_word(26, itype_word(mips_pkg::OP_LW, 1, 14, 8));
        store_word(27, itype_word(mips_pkg::OP_SW, 1, 14, 16));
        store_word(28, jump_word(28));
    endtask

    // instruction-set model running one instruction per call
    task automatic ref_step();
        mips_pkg::word_t      ins;
        mips_pkg::word_t      a;
        mips_pkg::word_t      b;
        mips_pkg::word_t      se;
        mips_pkg::word_t      ea;
        mips_pkg::word_t      res;
        mips_pkg::word_t      npc;
        mips_pkg::creg_addr_t dst;
        logic                 wr;
        ins = ref_mem[ref_pc[9:2]];
        a   = rf[ins[25:21]];
        b   = rf[ins[20:16]];
        se  = {{16{ins[15]}}, ins[15:0]};
        ea  = a + se;
        npc = ref_pc + 32'd4;
        dst = ins[20:16];
        res = '0;
        wr  = 1'b1;
        case (ins[31:26])
            mips_pkg::OP_SPECIAL: begin
                dst = ins[15:11];
                case (ins[5:0])
                    mips_pkg::FN_ADDU: res = a + b;
                    mips_pkg::FN_SUBU: res = a - b;
                    mips_pkg::FN_AND:  res = a & b;
                    mips_pkg::FN_OR:   res = a | b;
                    mips_pkg::FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
                    default:           wr  = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: res = a + se;
            mips_pkg::OP_LUI:   res = {ins[15:0], 16'h0000};
            mips_pkg::OP_LW: begin
                res = ref_mem[ea[9:2]];
                acc_wr_q.push_back(1'b0);
                acc_addr_q.push_back(ea);
                acc_data_q.push_back('0);
            end
            mips_pkg::OP_SW: begin
                wr = 1'b0;
                ref_mem[ea[9:2]] = b;
                acc_wr_q.push_back(1'b1);
                acc_addr_q.push_back(ea);
                acc_data_q.push_back(b);
            end
            // no delay slot so the offset is from pc+4
            mips_pkg::OP_BEQ: begin
                wr = 1'b0;
                if (a == b) npc = npc + {se[29:0], 2'b00};
            end
            mips_pkg::OP_BNE: begin
                wr = 1'b0;
                if (a != b) npc = npc + {se[29:0], 2'b00};
            end
            mips_pkg::OP_J: begin
                wr  = 1'b0;
                npc = {npc[31:28], ins[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && (dst != 5'd0)) begin
            rf[dst] = res;
            wb_pc_q.push_back(ref_pc);
            wb_num_q.push_back(dst);
            wb_data_q.push_back(res);
        end
        ref_pc = npc;
    endtask

    task automatic accept_fetch();
        check_val("inst_addr", inst_addr, ref_pc);
        check_val("debug_wb_pc", debug_wb_pc, ref_pc);
        check_val("inst_wr/inst_size", {29'b0, inst_wr, inst_size}, 32'h2);
        // previous instruction must be fully retired by now
        check_true(wb_pc_q.size() == 0, "a predicted register write never showed on the trace");
        check_true(acc_wr_q.size() == 0, "a predicted load or store never reached the data bus");
        if (ref_pc == LOOP_PC) begin
            done = 1'b1;
        end else begin
            ref_step();
        end
    endtask

    task automatic accept_data();
        logic            exp_wr;
        mips_pkg::word_t exp_addr;
        mips_pkg::word_t exp_data;
        check_val("data_size", {30'b0, data_size}, 32'h2);
        if (acc_wr_q.size() == 0) begin
            check_true(1'b0, "data bus access with no load or store in the reference model");
        end else begin
            exp_wr   = acc_wr_q.pop_front();
            exp_addr = acc_addr_q.pop_front();
            exp_data = acc_data_q.pop_front();
            check_val("data_wr", {31'b0, data_wr}, {31'b0, exp_wr});
            check_val("data_addr", data_addr, exp_addr);
            if (exp_wr) check_val("data_wdata", data_wdata, exp_data);
        end
        d_wr_q   = data_wr;
        d_addr_q = data_addr;
        if (data_wr) mem[data_addr[9:2]] = data_wdata;
    endtask

    task automatic serve_inst();
        if (!i_busy) begin
            if (i_held) begin
                check_true(inst_req, "inst_req dropped before addr_ok");
                check_val("inst_addr", inst_addr, i_hold_addr);
                check_val("inst_wr/inst_size", {29'b0, inst_wr, inst_size},
                          {29'b0, i_hold_ctrl});
                check_val("inst_wdata", inst_wdata, i_hold_wdata);
            end
            i_held = 1'b0;
            if (inst_req && (i_await != 2'd0)) begin
                // withhold addr_ok this cycle
                i_await      = i_await - 2'd1;
                i_held       = 1'b1;
                i_hold_addr  = inst_addr;
                i_hold_ctrl  = {inst_wr, inst_size};
                i_hold_wdata = inst_wdata;
            end else if (inst_req) begin
                inst_addr_ok = 1'b1;
                i_addr_q     = inst_addr;
                accept_fetch();
                i_dwait      = draw_delay();
                i_busy       = 1'b1;
            end
        end else begin
            check_true(!inst_req, "inst_req raised again with a fetch outstanding");
        end
        // zero data delay answers in the addr_ok cycle
        if (i_busy) begin
            if (i_dwait == 2'd0) begin
                inst_data_ok = 1'b1;
                inst_rdata   = mem[i_addr_q[9:2]];
                i_busy       = 1'b0;
                i_await      = draw_delay();
            end else begin
                i_dwait = i_dwait - 2'd1;
            end
        end
    endtask

    task automatic serve_data();
        if (!d_busy) begin
            if (d_held) begin
                check_true(data_req, "data_req dropped before addr_ok");
                check_val("data_addr", data_addr, d_hold_addr);
                check_val("data_wdata", data_wdata, d_hold_wdata);
                check_val("data_wr", {31'b0, data_wr}, {31'b0, d_hold_wr});
                check_val("data_size", {30'b0, data_size}, {30'b0, d_hold_size});
            end
            d_held = 1'b0;
            if (data_req && (d_await != 2'd0)) begin
                d_await      = d_await - 2'd1;
                d_held       = 1'b1;
                d_hold_wr    = data_wr;
                d_hold_size  = data_size;
                d_hold_addr  = data_addr;
                d_hold_wdata = data_wdata;
            end else if (data_req) begin
                data_addr_ok = 1'b1;
                accept_data();
                d_dwait      = draw_delay();
                d_busy       = 1'b1;
            end
        end else begin
            check_true(!data_req, "data_req raised again with an access outstanding");
        end
        if (d_busy) begin
            if (d_dwait == 2'd0) begin
                data_data_ok = 1'b1;
                if (!d_wr_q) data_rdata = mem[d_addr_q[9:2]];
                d_busy       = 1'b0;
                d_await      = draw_delay();
            end else begin
                d_dwait = d_dwait - 2'd1;
            end
        end
    endtask

    task automatic check_trace();
        if (debug_wb_rf_wen != 4'h0) begin
            if (wb_pc_q.size() == 0) begin
                check_true(1'b0, "register write on the trace that the reference model lacks");
            end else begin
                check_val("debug_wb_rf_wen", {28'b0, debug_wb_rf_wen}, 32'hf);
                check_val("debug_wb_pc", debug_wb_pc, wb_pc_q.pop_front());
                check_val("debug_wb_rf_wnum", {27'b0, debug_wb_rf_wnum},
                          {27'b0, wb_num_q.pop_front()});
                check_val("debug_wb_rf_wdata", debug_wb_rf_wdata, wb_data_q.pop_front());
            end
        end
    endtask

    // bus slaves drive 1 ns after the edge
    always @(posedge clk) begin
        #1;
        inst_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        inst_rdata   = IDLE_RDATA;
        data_rdata   = IDLE_RDATA;
        serve_inst();
        serve_data();
        check_trace();
    end

    // quiet outputs through reset and one cycle past it
    always @(negedge clk) begin
        if (rst_n) post_rst_cnt++;
        if (post_rst_cnt < 2) begin
            check_val("inst_req", {31'b0, inst_req}, 32'h0);
            check_val("data_req", {31'b0, data_req}, 32'h0);
            check_val("debug_wb_rf_wen", {28'b0, debug_wb_rf_wen}, 32'h0);
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the self-loop was reached");
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        inst_rdata   = IDLE_RDATA;
        data_rdata   = IDLE_RDATA;
        inst_addr_ok = 1'b0;
        data_addr_ok = 1'b0;
        inst_data_ok = 1'b0;
        data_data_ok = 1'b0;
        n_checks     = 0;
        n_errors     = 0;
        post_rst_cnt = 0;
        done         = 1'b0;
        i_busy       = 1'b0;
        i_held       = 1'b0;
        d_busy       = 1'b0;
        d_held       = 1'b0;
        ref_pc       = BASE;
        for (int r = 0; r < 32; r++) begin
            rf[r] = '0;
        end
        load_program();
        i_await = draw_delay();
        d_await = draw_delay();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait (done);
        repeat (3) @(posedge clk);
        // data area against the reference memory
        for (int i = 128; i < 136; i++) begin
            check_val($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
        end
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
mips_pkg.sv
handshake.sv
regfile.sv
alu.sv
decoder.sv
datapath.sv
mycpu.sv
tb_mycpu.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mycpu -f tb.f -o tb_mycpu \
    || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/tb_mycpu)
echo "$sim_out"
echo "$sim_out" | grep -qx "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
